//--- hw/pdp_med_pkg.sv
`default_nettype none

package pdp_med_pkg;

    // ******************************************************************
    // sample and packed word types
    // ******************************************************************

    // one signed pooling sample.
    typedef logic signed [7:0] sample_t;

    // packed partial result, single, pair or triple form.
    typedef logic [21:0] med_word_t;

    // upper three bits of a sample.
    typedef logic [2:0] msb3_t;

    // compressed code of a sorted msb triple.
    typedef logic [6:0] lut_code_t;

    // ******************************************************************
    // configuration
    // ******************************************************************

    // window code: 0 one sample, 1 two, 2 three.
    typedef logic [2:0] kernel_width_t;

    typedef struct packed {
        logic          enable;
        kernel_width_t kernel_width;
    } med_cfg_t;

    // marks a pair word in bits 21..20.
    localparam logic [1:0] PAIR_TAG = 2'd3;

endpackage

`default_nettype wire

//--- hw/med1d_lut.sv
`timescale 1ns/1ps
`default_nettype none

module med1d_lut (
    input  wire pdp_med_pkg::msb3_t [2:0] encode_msbs,
    input  wire pdp_med_pkg::lut_code_t   code,
    output pdp_med_pkg::lut_code_t        enc_code,
    output pdp_med_pkg::msb3_t [2:0]      dec_msbs
);

    import pdp_med_pkg::*;

    localparam int LUT_SIZE = 120;

    // index 2 is the max field, index 0 the min field.
    typedef msb3_t [2:0] msb_triple_t;
    typedef msb_triple_t [LUT_SIZE-1:0] lut_table_t;

    // ******************************************************************
    // table of all non-increasing msb triples
    // ******************************************************************

    // fields are two's complement, so signed sample order carries over.
    // loop values run in offset binary and flip the top bit back.
    function automatic lut_table_t build_table();
        lut_table_t tbl;
        int         idx;
        tbl = '0;
        idx = 0;
        for (int a = 0; a < 8; a++) begin
            for (int b = 0; b <= a; b++) begin
                for (int c = 0; c <= b; c++) begin
                    tbl[idx][2] = msb3_t'(a) ^ 3'b100;
                    tbl[idx][1] = msb3_t'(b) ^ 3'b100;
                    tbl[idx][0] = msb3_t'(c) ^ 3'b100;
                    idx++;
                end
            end
        end
        return tbl;
    endfunction

    localparam lut_table_t LUT_TABLE = build_table();

    // encoder searches the table for the matching entry.
    always_comb begin
        enc_code = '0;
        for (int i = 0; i < LUT_SIZE; i++) begin
            if (LUT_TABLE[i] == encode_msbs) begin
                enc_code = lut_code_t'(i);
            end
        end
    end

    // codes past the table end decode to zero.
    always_comb begin
        if (int'(code) < LUT_SIZE) begin
            dec_msbs = LUT_TABLE[code];
        end else begin
            dec_msbs = '0;
        end
    end

    // round trip through the table for every sorted triple.
    always_comb begin
        if ($signed(encode_msbs[2]) >= $signed(encode_msbs[1]) &&
            $signed(encode_msbs[1]) >= $signed(encode_msbs[0])) begin
            assert final (LUT_TABLE[enc_code] == encode_msbs)
                else $error("med1d_lut: encoded triple does not decode back");
        end
    end

endmodule

`default_nettype wire

//--- hw/med1d_core.sv
`timescale 1ns/1ps
`default_nettype none

module med1d_core (
    input  wire pdp_med_pkg::med_word_t     acc,
    input  wire                             acc_empty,
    input  wire pdp_med_pkg::kernel_width_t kernel_width,
    input  wire pdp_med_pkg::sample_t       sample,
    output pdp_med_pkg::med_word_t          next
);

    import pdp_med_pkg::*;

    logic      acc_is_pair;
    sample_t   single_val;
    sample_t   pair_lo;
    sample_t   pair_hi;
    med_word_t op_single;
    med_word_t op_pair;
    med_word_t op_triple;
    sample_t   tri_max;
    sample_t   tri_mid;
    sample_t   tri_min;
    msb3_t [2:0] tri_msbs;
    lut_code_t tri_code;

    // pair words carry the tag over four zero bits.
    assign acc_is_pair = (acc[21:16] == {PAIR_TAG, 4'b0000});
    assign single_val  = sample_t'(acc[7:0]);
    assign pair_lo     = sample_t'(acc[15:8]);
    assign pair_hi     = sample_t'(acc[7:0]);

    // ******************************************************************
    // zero discard and pair sort
    // ******************************************************************

    assign op_single = {{14{sample[7]}}, sample};

    always_comb begin
        if (sample < single_val) begin
            op_pair = {PAIR_TAG, 4'b0000, sample, single_val};
        end else begin
            op_pair = {PAIR_TAG, 4'b0000, single_val, sample};
        end
    end

    // ******************************************************************
    // triple sort with msb compression
    // ******************************************************************

    // the pair is already ordered, only the new sample needs a slot.
    always_comb begin
        if (sample >= pair_hi) begin
            tri_max = sample;
            tri_mid = pair_hi;
            tri_min = pair_lo;
        end else if (sample >= pair_lo) begin
            tri_max = pair_hi;
            tri_mid = sample;
            tri_min = pair_lo;
        end else begin
            tri_max = pair_hi;
            tri_mid = pair_lo;
            tri_min = sample;
        end
    end

    assign tri_msbs[2] = tri_max[7:5];
    assign tri_msbs[1] = tri_mid[7:5];
    assign tri_msbs[0] = tri_min[7:5];

    med1d_lut lut_enc_inst (
        .encode_msbs (tri_msbs),
        .code        ('0),
        .enc_code    (tri_code),
        .dec_msbs    ()
    );

    assign op_triple = {tri_code, tri_min[4:0], tri_mid[4:0], tri_max[4:0]};

    // operator select.
    always_comb begin
        if (acc_empty) begin
            next = op_single;
        end else if (acc_is_pair && kernel_width == 3'd2) begin
            next = op_triple;
        end else begin
            next = op_pair;
        end
    end

    // a two sample window never sees a pair come back.
    always_comb begin
        assert final (!(!acc_empty && acc_is_pair && kernel_width == 3'd1))
            else $error("med1d_core: pair word in accumulator with width code 1");
    end

endmodule

`default_nettype wire

//--- hw/med1d_extract.sv
`timescale 1ns/1ps
`default_nettype none

module med1d_extract (
    input  wire pdp_med_pkg::med_word_t     word,
    input  wire pdp_med_pkg::kernel_width_t kernel_width,
    output pdp_med_pkg::sample_t            median
);

    import pdp_med_pkg::*;

    lut_code_t   tri_code;
    msb3_t [2:0] tri_msbs;

    // triple code sits in the top seven bits.
    assign tri_code = word[21:15];

    med1d_lut lut_dec_inst (
        .encode_msbs ('0),
        .code        (tri_code),
        .enc_code    (),
        .dec_msbs    (tri_msbs)
    );

    // ******************************************************************
    // median select per window width
    // ******************************************************************

    always_comb begin
        case (kernel_width)
            3'd0: begin
                median = sample_t'(word[7:0]);
            end
            3'd1: begin
                // lower median of the pair.
                median = sample_t'(word[15:8]);
            end
            default: begin
                // middle msbs from the code, low bits stored in the word.
                median = sample_t'({tri_msbs[1], word[9:5]});
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/med1d_regs.sv
`timescale 1ns/1ps
`default_nettype none

module med1d_regs #(
    parameter pdp_med_pkg::med_cfg_t RESET_CFG = '{enable: 1'b1, kernel_width: 3'd2}
) (
    input  wire                        nvdla_core_clk,
    input  wire                        rst_n,
    input  wire                        cfg_we,
    input  wire pdp_med_pkg::med_cfg_t cfg_wdata,
    output pdp_med_pkg::med_cfg_t      cfg,
    output logic                       cfg_changed,
    output logic                       cfg_err
);

    import pdp_med_pkg::*;

    logic width_legal;

    assign width_legal = (cfg_wdata.kernel_width <= 3'd2);

    // accepted writes update cfg and pulse cfg_changed.
    // illegal widths only pulse cfg_err.
    always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg         <= RESET_CFG;
            cfg_changed <= 1'b0;
            cfg_err     <= 1'b0;
        end else begin
            cfg_changed <= cfg_we && width_legal;
            cfg_err     <= cfg_we && !width_legal;
            if (cfg_we && width_legal) begin
                cfg <= cfg_wdata;
            end
        end
    end

    // datapath relies on a legal width at all times.
    a_cfg_width_legal: assert property (
        @(posedge nvdla_core_clk) disable iff (!rst_n)
        cfg.kernel_width <= 3'd2
    ) else $error("med1d_regs: illegal kernel width in cfg");

endmodule

`default_nettype wire

//--- hw/med1d_line.sv
`timescale 1ns/1ps
`default_nettype none

module med1d_line (
    input  wire                        nvdla_core_clk,
    input  wire                        rst_n,
    input  wire pdp_med_pkg::med_cfg_t cfg,
    input  wire                        cfg_changed,
    input  wire                        in_valid,
    input  wire pdp_med_pkg::sample_t  in_sample,
    output logic                       out_valid,
    output pdp_med_pkg::sample_t       out_median
);

    import pdp_med_pkg::*;

    med_word_t  acc;
    logic       acc_empty;
    logic [1:0] count;
    logic       take;
    logic       empty_eff;
    logic [1:0] count_eff;
    logic       window_done;
    med_word_t  next_word;
    sample_t    median;

    // ******************************************************************
    // window tracking
    // ******************************************************************

    assign take = in_valid && cfg.enable;

    // a config change drops the partial window this cycle.
    // a sample arriving now starts the next one.
    assign empty_eff   = acc_empty || cfg_changed;
    assign count_eff   = cfg_changed ? 2'd0 : count;
    assign window_done = ({1'b0, count_eff} == cfg.kernel_width);

    med1d_core core_inst (
        .acc          (acc),
        .acc_empty    (empty_eff),
        .kernel_width (cfg.kernel_width),
        .sample       (in_sample),
        .next         (next_word)
    );

    med1d_extract extract_inst (
        .word         (next_word),
        .kernel_width (cfg.kernel_width),
        .median       (median)
    );

    always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_empty <= 1'b1;
            count     <= 2'd0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= take && window_done;
            if (take) begin
                if (window_done) begin
                    acc_empty <= 1'b1;
                    count     <= 2'd0;
                end else begin
                    acc_empty <= 1'b0;
                    count     <= count_eff + 2'd1;
                end
            end else if (cfg_changed) begin
                acc_empty <= 1'b1;
                count     <= 2'd0;
            end
        end
    end

    // ******************************************************************
    // payload registers
    // ******************************************************************

    always_ff @(posedge nvdla_core_clk) begin
        if (take && !window_done) begin
            acc <= next_word;
        end
        if (take && window_done) begin
            out_median <= median;
        end
    end

    // windows of two or three samples never give results in adjacent cycles.
    a_out_valid_pulse: assert property (
        @(posedge nvdla_core_clk) disable iff (!rst_n)
        (out_valid && cfg.kernel_width != 3'd0) |=> !out_valid
    ) else $error("med1d_line: back-to-back out_valid with a window longer than one");

endmodule

`default_nettype wire

//--- hw/med1d_top.sv
`timescale 1ns/1ps
`default_nettype none

module med1d_top #(
    parameter pdp_med_pkg::med_cfg_t RESET_CFG = '{enable: 1'b1, kernel_width: 3'd2}
) (
    input  wire                        nvdla_core_clk,
    input  wire                        rst_n,
    input  wire                        cfg_we,
    input  wire pdp_med_pkg::med_cfg_t cfg_wdata,
    output logic                       cfg_err,
    input  wire                        in_valid,
    input  wire pdp_med_pkg::sample_t  in_sample,
    output logic                       out_valid,
    output pdp_med_pkg::sample_t       out_median
);

    import pdp_med_pkg::*;

    med_cfg_t cfg;
    logic     cfg_changed;

    med1d_regs #(
        .RESET_CFG (RESET_CFG)
    ) regs_inst (
        .nvdla_core_clk (nvdla_core_clk),
        .rst_n          (rst_n),
        .cfg_we         (cfg_we),
        .cfg_wdata      (cfg_wdata),
        .cfg            (cfg),
        .cfg_changed    (cfg_changed),
        .cfg_err        (cfg_err)
    );

    med1d_line line_inst (
        .nvdla_core_clk (nvdla_core_clk),
        .rst_n          (rst_n),
        .cfg            (cfg),
        .cfg_changed    (cfg_changed),
        .in_valid       (in_valid),
        .in_sample      (in_sample),
        .out_valid      (out_valid),
        .out_median     (out_median)
    );

endmodule

`default_nettype wire

//--- sim/tb_med1d_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_med1d_top;

    import pdp_med_pkg::*;

    localparam string CASES_FILE = "sim/med1d_cases.txt";

    logic     nvdla_core_clk;
    logic     rst_n;
    logic     cfg_we;
    med_cfg_t cfg_wdata;
    logic     cfg_err;
    logic     in_valid;
    sample_t  in_sample;
    logic     out_valid;
    sample_t  out_median;

    // expected medians in the order the results must appear.
    int exp_q[$];
    int err_next = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    med1d_top med1d_top_inst (
        .nvdla_core_clk (nvdla_core_clk),
        .rst_n          (rst_n),
        .cfg_we         (cfg_we),
        .cfg_wdata      (cfg_wdata),
        .cfg_err        (cfg_err),
        .in_valid       (in_valid),
        .in_sample      (in_sample),
        .out_valid      (out_valid),
        .out_median     (out_median)
    );

    // ******************************************************************
    // clock, failure handling and cycle limit
    // ******************************************************************

    initial begin
        nvdla_core_clk = 1'b0;
        forever #2 nvdla_core_clk = ~nvdla_core_clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            fail_run($sformatf("Error at %0t ns: %s is %0d, expected %0d",
                               $time, name, actual, expected));
        end
    endtask

    always @(posedge nvdla_core_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            fail_run($sformatf("run did not finish within %0d cycles", cycle_limit));
        end
    end

    // results are stable at the falling edge.
    always @(negedge nvdla_core_clk) begin
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                fail_run("out_valid pulsed but no expected median was left");
            end else begin
                check_value("out_median", int'(out_median), exp_q.pop_front());
            end
        end
    end

    // ******************************************************************
    // stimulus
    // ******************************************************************

    // advances one cycle and sets the inputs back to idle 1 ns after the edge.
    task automatic step_cycle();
        @(posedge nvdla_core_clk);
        #1;
        check_value("cfg_err", int'(cfg_err), err_next);
        err_next = 0;
        in_valid = 1'b0;
        cfg_we   = 1'b0;
    endtask

    task automatic drive_sample(input int value);
        step_cycle();
        in_valid  = 1'b1;
        in_sample = sample_t'(value);
    endtask

    // cfg_err is due in the cycle after the write.
    task automatic write_config(input int enable, input int width, input int err);
        step_cycle();
        cfg_we                 = 1'b1;
        cfg_wdata.enable       = enable[0];
        cfg_wdata.kernel_width = kernel_width_t'(width);
        err_next               = err;
    endtask

    initial begin : main
        int               fd;
        int               rc;
        int               num_lines;
        int               arg_a;
        int               arg_b;
        int               arg_c;
        logic [7:0]       op;
        logic [8*128-1:0] line_buf;
        bit               done;

        rst_n     = 1'b0;
        cfg_we    = 1'b0;
        cfg_wdata = '0;
        in_valid  = 1'b0;
        in_sample = '0;

        // line count sets the cycle limit.
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            fail_run("could not open the cases file");
        end
        num_lines = 0;
        while (!$feof(fd)) begin
            rc = $fgets(line_buf, fd);
            if (rc > 0) begin
                num_lines++;
            end
        end
        $fclose(fd);
        cycle_limit = 4 * num_lines + 100;

        repeat (4) @(posedge nvdla_core_clk);
        #1;
        rst_n = 1'b1;

        fd   = $fopen(CASES_FILE, "r");
        done = 1'b0;
        while (!done) begin
            rc = $fscanf(fd, "%s", op);
            if (rc != 1) begin
                done = 1'b1;
            end else begin
                case (op)
                    "#": rc = $fgets(line_buf, fd);
                    "S": begin
                        rc = $fscanf(fd, "%d", arg_a);
                        drive_sample(arg_a);
                    end
                    "E": begin
                        rc = $fscanf(fd, "%d", arg_a);
                        exp_q.push_back(arg_a);
                    end
                    "I": step_cycle();
                    // a flush is a write that lands inside a window.
                    "W", "F": begin
                        rc = $fscanf(fd, "%d %d %d", arg_a, arg_b, arg_c);
                        write_config(arg_a, arg_b, arg_c);
                    end
                    default: fail_run($sformatf("unknown operation %s in the cases file", op));
                endcase
            end
        end
        $fclose(fd);

        // drain the last result.
        repeat (4) step_cycle();

        if (exp_q.size() != 0) begin
            fail_run($sformatf("%0d expected medians never appeared", exp_q.size()));
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sim/med1d_cases.txt
# W/F enable width err : config write or flush, S sample, E median, I idle
# medians by signed order: the value, the lower of two, the middle of three
# default width code 2 after reset
S -5
S 3
S 0
E 0
S 127
S -128
S 127
E 127
S -128
S -128
S 0
E -128
# pairs give the lower value
W 1 1 0
S -3
S -7
E -7
S 100
S -100
E -100
# single samples pass through
W 1 0 0
S 42
E 42
S 0
E 0
# illegal width is rejected, width stays 0
W 1 5 1
S -1
E -1
# flush drops the partial window
W 1 2 0
S 10
S 20
F 1 2 0
S 1
S 2
S 3
E 2
# disabled samples are ignored
W 0 2 0
S 5
S 6
S 7
I
W 1 2 0
S 1
S 2
S 3
E 2
S -1
S -2
S -3
E -2
# triples across many msb fields
S 77
S -45
S 12
E 12
S -99
S -70
S 101
E -70
S 33
S 63
S -1
E 33
S -33
S -64
S -65
E -64
S 95
S 96
S 64
E 95
S -128
S 31
S -97
E -97
S -6
S 117
S 0
E 0
S -81
S 44
S -50
E -50
S 126
S -127
S 89
E 89
S 15
S -16
S -2
E -2

//--- build.f
hw/pdp_med_pkg.sv
hw/med1d_lut.sv
hw/med1d_core.sv
hw/med1d_extract.sv
hw/med1d_regs.sv
hw/med1d_line.sv
hw/med1d_top.sv
sim/tb_med1d_top.sv

//--- run.sh
#!/bin/sh
# build the testbench with verilator and run it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -Wno-fatal --top-module tb_med1d_top \
    -Mdir obj_dir -o sim_med1d -f build.f

# the simulator exits nonzero on failure, the log decides
./obj_dir/sim_med1d > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
    exit 0
fi
exit 1
